//--- logic/rv_isa_pkg.sv
package rv_isa_pkg;

  // architectural register width for RV32
  localparam int XLEN = 32;

  // one register-width value
  // signedness is decided per operation, so the type itself is unsigned
  typedef logic [XLEN-1:0] word_t;

  // M-extension divide group, encoded by funct3 alone
  // the multiply codes 0..3 share funct7 but do not reach this unit
  typedef enum logic [2:0] {
    DIV  = 3'b100,
    DIVU = 3'b101,
    REM  = 3'b110,
    REMU = 3'b111
  } div_op_e;

endpackage

//--- logic/div_pipe_pkg.sv
package div_pipe_pkg;

  import rv_isa_pkg::*;

  // quotient bits retired by each registered slice
  localparam int BITS_PER_STAGE = 4;

  // slices needed to consume every dividend bit
  localparam int NUM_STAGES = XLEN / BITS_PER_STAGE;

  // operand prep and result fixup each add one register
  localparam int DIV_LATENCY = NUM_STAGES + 2;

  // request as presented by the issuing side
  typedef struct packed {
    logic    valid;
    div_op_e op;
    word_t   dividend;
    word_t   divisor;
  } div_req_t;

  // sign and select decisions made at the front and applied at the back
  typedef struct packed {
    logic want_rem;
    logic negate_q;
    logic negate_r;
  } div_ctl_t;

  // word carried from slice to slice
  // quo starts as the dividend magnitude; each step shifts one dividend bit
  // out of the top and one quotient bit in at the bottom
  typedef struct packed {
    logic     valid;
    div_ctl_t ctl;
    word_t    rem;
    word_t    quo;
    word_t    divisor;
  } div_work_t;

  // response handed back to the consumer
  typedef struct packed {
    logic  valid;
    word_t result;
  } div_rsp_t;

endpackage

//--- logic/div_operand_prep.sv
`timescale 1ns/1ps

module div_operand_prep
  import rv_isa_pkg::*;
  import div_pipe_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  div_req_t  req_i,
  output div_work_t work_o
);

  logic     is_signed;
  logic     want_rem;
  logic     dividend_neg;
  logic     divisor_neg;
  logic     divisor_zero;
  word_t    dividend_mag;
  word_t    divisor_mag;
  div_ctl_t ctl_d;

  // opcode decode
  always_comb begin
    case (req_i.op)
      DIV: begin
        is_signed = 1'b1;
        want_rem  = 1'b0;
      end
      REM: begin
        is_signed = 1'b1;
        want_rem  = 1'b1;
      end
      REMU: begin
        is_signed = 1'b0;
        want_rem  = 1'b1;
      end
      default: begin
        // DIVU, and anything outside the divide group
        is_signed = 1'b0;
        want_rem  = 1'b0;
      end
    endcase
  end

  // sign bits only count for the signed ops
  assign dividend_neg = is_signed & req_i.dividend[XLEN-1];
  assign divisor_neg  = is_signed & req_i.divisor[XLEN-1];
  assign divisor_zero = (req_i.divisor == '0);

  // two's-complement magnitudes
  // the most negative value maps onto itself, which reads correctly as unsigned
  assign dividend_mag = dividend_neg ? (~req_i.dividend) + 1'b1 : req_i.dividend;
  assign divisor_mag  = divisor_neg ? (~req_i.divisor) + 1'b1 : req_i.divisor;

  // a zero divisor keeps the all-ones quotient positive
  // the remainder always follows the dividend sign
  assign ctl_d.want_rem = want_rem;
  assign ctl_d.negate_q = (dividend_neg ^ divisor_neg) & ~divisor_zero;
  assign ctl_d.negate_r = dividend_neg;

  always_ff @(posedge clk) begin
    if (rst) begin
      work_o.valid <= 1'b0;
    end else begin
      work_o.valid <= req_i.valid;
    end
    work_o.ctl     <= ctl_d;
    // partial remainder starts empty
    work_o.rem     <= '0;
    work_o.quo     <= dividend_mag;
    work_o.divisor <= divisor_mag;
  end

endmodule

//--- logic/div_stage.sv
`timescale 1ns/1ps

module div_stage
  import rv_isa_pkg::*;
  import div_pipe_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  div_work_t work_i,
  output div_work_t work_o
);

  // running values while the steps unroll
  word_t           rem_d;
  word_t           quo_d;
  // one bit wider than a word so the trial subtract shows its borrow
  logic [XLEN:0]   shifted;
  logic [XLEN:0]   diff;

  // BITS_PER_STAGE steps of restoring division, all in one cycle
  always_comb begin
    rem_d   = work_i.rem;
    quo_d   = work_i.quo;
    shifted = '0;
    diff    = '0;
    for (int i = 0; i < BITS_PER_STAGE; i++) begin
      // bring down the next dividend bit
      shifted = {rem_d, quo_d[XLEN-1]};
      // trial subtract
      diff    = shifted - {1'b0, work_i.divisor};
      // top bit of diff set means the divisor did not fit
      if (diff[XLEN]) begin
        rem_d = shifted[XLEN-1:0];
      end else begin
        rem_d = diff[XLEN-1:0];
      end
      // quotient bit enters where the dividend bit left
      quo_d = {quo_d[XLEN-2:0], ~diff[XLEN]};
    end
  end

  // with a zero divisor every trial succeeds, so the quotient fills with ones
  // and the dividend bits end up in rem unchanged

  always_ff @(posedge clk) begin
    if (rst) begin
      work_o.valid <= 1'b0;
    end else begin
      work_o.valid <= work_i.valid;
    end
    work_o.ctl     <= work_i.ctl;
    work_o.rem     <= rem_d;
    work_o.quo     <= quo_d;
    work_o.divisor <= work_i.divisor;
  end

endmodule

//--- logic/div_result_fixup.sv
`timescale 1ns/1ps

module div_result_fixup
  import rv_isa_pkg::*;
  import div_pipe_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  div_work_t work_i,
  output div_rsp_t  rsp_o
);

  word_t quo_fix;
  word_t rem_fix;
  word_t result_d;

  // restore signs decided at the front of the pipe
  assign quo_fix = work_i.ctl.negate_q ? (~work_i.quo) + 1'b1 : work_i.quo;
  assign rem_fix = work_i.ctl.negate_r ? (~work_i.rem) + 1'b1 : work_i.rem;

  // DIV/DIVU want the quotient, REM/REMU the remainder
  assign result_d = work_i.ctl.want_rem ? rem_fix : quo_fix;

  // most negative over minus one yields quotient magnitude 0x80000000 and no negation
  // so the most negative value comes back and the remainder is zero

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_o.valid <= 1'b0;
    end else begin
      rsp_o.valid <= work_i.valid;
    end
    rsp_o.result <= result_d;
  end

endmodule

//--- logic/div_unit.sv
`timescale 1ns/1ps

module div_unit
  import div_pipe_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  div_req_t req_i,
  output div_rsp_t rsp_o
);

  // link[0] leaves prep, link[NUM_STAGES] enters fixup
  div_work_t link [NUM_STAGES+1];

  div_operand_prep u_prep (
    .clk    (clk),
    .rst    (rst),
    .req_i  (req_i),
    .work_o (link[0])
  );

  // each slice retires BITS_PER_STAGE quotient bits
  for (genvar g = 0; g < NUM_STAGES; g++) begin : gen_stage
    div_stage u_stage (
      .clk    (clk),
      .rst    (rst),
      .work_i (link[g]),
      .work_o (link[g+1])
    );
  end

  div_result_fixup u_fixup (
    .clk    (clk),
    .rst    (rst),
    .work_i (link[NUM_STAGES]),
    .rsp_o  (rsp_o)
  );

endmodule

//--- test/div_unit_tb.sv
`timescale 1ns/1ps

module div_unit_tb
  import rv_isa_pkg::*;
  import div_pipe_pkg::*;
();

  logic     clk;
  logic     rst;
  div_req_t req_i;
  div_rsp_t rsp_o;

  // expected results in issue order
  word_t       exp_q [$];
  int          errors;
  int          checks;
  int          tests;
  int          rsp_count;
  logic [31:0] lfsr_state;

  div_unit dut (
    .clk   (clk),
    .rst   (rst),
    .req_i (req_i),
    .rsp_o (rsp_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // one LFSR step per bit taken
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // RISC-V M-extension divide semantics
  // signed division truncates toward zero, remainder takes the dividend sign
  function automatic word_t ref_div(input div_op_e op, input word_t a, input word_t b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic               overflow;
    word_t              r;
    sa       = a;
    sb       = b;
    overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (op)
      DIV: begin
        if (b == '0) begin
          r = 32'hffff_ffff;
        end else if (overflow) begin
          r = 32'h8000_0000;
        end else begin
          r = sa / sb;
        end
      end
      DIVU: begin
        if (b == '0) begin
          r = 32'hffff_ffff;
        end else begin
          r = a / b;
        end
      end
      REM: begin
        if (b == '0) begin
          r = a;
        end else if (overflow) begin
          r = '0;
        end else begin
          r = sa % sb;
        end
      end
      default: begin
        // REMU
        if (b == '0) begin
          r = a;
        end else begin
          r = a % b;
        end
      end
    endcase
    return r;
  endfunction

  task automatic check_result(input string name, input word_t exp, input word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_valid(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  // outputs are sampled on the falling edge, where they are stable
  always @(negedge clk) begin
    if (!rst && rsp_o.valid === 1'b1) begin
      rsp_count++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("error at %0t: rsp_o valid with no pending request", $time);
      end else begin
        check_result("rsp_o.result", exp_q.pop_front(), rsp_o.result);
      end
    end
  end

  task automatic send_req(input div_op_e op, input word_t a, input word_t b);
    @(posedge clk);
    req_i <= '{valid: 1'b1, op: op, dividend: a, divisor: b};
    exp_q.push_back(ref_div(op, a, b));
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      req_i.valid <= 1'b0;
    end
  endtask

  // wait for the expected queue to empty, then let the pipe settle
  task automatic drain_pipe(input int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("timeout: %0d results still pending after %0d cycles", exp_q.size(), limit);
      exp_q.delete();
    end
    n = 0;
    while (n < DIV_LATENCY + 2) begin
      @(negedge clk);
      n++;
    end
  endtask

  task automatic report_test(input string name, input int start_err);
    tests++;
    $display("test %-18s done, %0d errors", name, errors - start_err);
  endtask

  task automatic quiet_after_reset();
    int start_err;
    start_err = errors;
    for (int i = 0; i < 12; i++) begin
      @(negedge clk);
      check_valid("rsp_o.valid", 1'b0, rsp_o.valid);
    end
    report_test("quiet_after_reset", start_err);
  endtask

  task automatic single_latency();
    int start_err;
    int n;
    start_err = errors;
    send_req(DIVU, 32'd1000, 32'd7);
    // the DUT samples the request on this edge
    idle_cycles(1);
    // n counts the cycles from the sampling edge up to the result
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (rsp_o.valid !== 1'b1 && n < 40);
    if (rsp_o.valid !== 1'b1) begin
      errors++;
      $display("timeout: no response within 40 cycles of a single request");
    end else begin
      check_count("rsp_o latency", DIV_LATENCY, n);
      @(negedge clk);
      check_valid("rsp_o.valid", 1'b0, rsp_o.valid);
    end
    drain_pipe(20);
    report_test("single_latency", start_err);
  endtask

  task automatic random_burst();
    int          start_err;
    int          start_cnt;
    logic [31:0] sel;
    logic [31:0] shape;
    word_t       a;
    word_t       b;
    start_err = errors;
    start_cnt = rsp_count;
    for (int i = 0; i < 200; i++) begin
      rand_bits(2, sel);
      rand_bits(32, a);
      rand_bits(32, b);
      rand_bits(2, shape);
      // mix in small and small negative divisors
      case (shape[1:0])
        2'd0: b = b >> 24;
        2'd1: b = b >> 29;
        2'd2: b = ~(b >> 28);
        default: b = b;
      endcase
      send_req(div_op_e'({1'b1, sel[1:0]}), a, b);
    end
    idle_cycles(1);
    drain_pipe(50);
    check_count("rsp_o valid count", 200, rsp_count - start_cnt);
    report_test("random_burst", start_err);
  endtask

  task automatic zero_divisor();
    int    start_err;
    word_t dvd [6];
    start_err = errors;
    dvd[0] = 32'd0;
    dvd[1] = 32'd12345;
    dvd[2] = 32'h7fff_ffff;
    dvd[3] = 32'hffff_ffff;
    dvd[4] = 32'h8000_0000;
    dvd[5] = 32'hffff_fff9;
    for (int k = 0; k < 4; k++) begin
      for (int i = 0; i < 6; i++) begin
        send_req(div_op_e'(3'd4 + k), dvd[i], 32'd0);
      end
    end
    idle_cycles(1);
    drain_pipe(50);
    report_test("zero_divisor", start_err);
  endtask

  task automatic sign_cases();
    int    start_err;
    word_t mag_a;
    word_t mag_b;
    word_t a;
    word_t b;
    start_err = errors;
    // most negative over minus one
    send_req(DIV, 32'h8000_0000, 32'hffff_ffff);
    send_req(REM, 32'h8000_0000, 32'hffff_ffff);
    send_req(DIVU, 32'h8000_0000, 32'hffff_ffff);
    send_req(REMU, 32'h8000_0000, 32'hffff_ffff);
    for (int p = 0; p < 2; p++) begin
      mag_a = (p == 0) ? 32'd7 : 32'd100;
      mag_b = (p == 0) ? 32'd2 : 32'd3;
      for (int s = 0; s < 4; s++) begin
        a = s[0] ? 32'd0 - mag_a : mag_a;
        b = s[1] ? 32'd0 - mag_b : mag_b;
        for (int k = 0; k < 4; k++) begin
          send_req(div_op_e'(3'd4 + k), a, b);
        end
      end
    end
    idle_cycles(1);
    drain_pipe(50);
    report_test("sign_cases", start_err);
  endtask

  task automatic sparse_traffic();
    int          start_err;
    int          start_cnt;
    logic [31:0] sel;
    logic [31:0] gap;
    word_t       a;
    word_t       b;
    start_err = errors;
    start_cnt = rsp_count;
    for (int i = 0; i < 60; i++) begin
      rand_bits(2, sel);
      rand_bits(32, a);
      rand_bits(16, b);
      send_req(div_op_e'({1'b1, sel[1:0]}), a, b);
      rand_bits(3, gap);
      idle_cycles(gap);
    end
    idle_cycles(1);
    drain_pipe(50);
    check_count("rsp_o valid count", 60, rsp_count - start_cnt);
    report_test("sparse_traffic", start_err);
  endtask

  initial begin
    rst        = 1'b1;
    req_i      = '0;
    lfsr_state = 32'ha837;
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    quiet_after_reset();
    single_latency();
    random_burst();
    zero_divisor();
    sign_cases();
    sparse_traffic();

    if (exp_q.size() != 0) begin
      errors++;
      $display("error: %0d expected results never appeared", exp_q.size());
    end
    $display("summary: %0d tests, %0d checks, %0d results, %0d errors",
             tests, checks, rsp_count, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- compile.f
logic/rv_isa_pkg.sv
logic/div_pipe_pkg.sv
logic/div_operand_prep.sv
logic/div_stage.sv
logic/div_result_fixup.sv
logic/div_unit.sv
test/div_unit_tb.sv

//--- Bender.yml
package:
  name: div_unit

sources:
  # packages first, the pipe package imports the ISA package
  - files:
      - logic/rv_isa_pkg.sv
      - logic/div_pipe_pkg.sv

  # divider pipeline, leaf modules before the top level
  - files:
      - logic/div_operand_prep.sv
      - logic/div_stage.sv
      - logic/div_result_fixup.sv
      - logic/div_unit.sv

  # testbench
  - target: test
    files:
      - test/div_unit_tb.sv
